//--- source/mem_defs.svh
// Width and count macros for the shared memory port, included by the packages and the testbench
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Byte address width on the memory bus
`define MEM_ADDR_WIDTH 32

// One memory line, also the client data width
`define MEM_LINE_WIDTH 64

// Response tag width
`define MEM_TAG_WIDTH 4

// Tag values, zero reserved for "no response"
`define NUM_MEM_TAGS 16

`endif

//--- source/mem_bus_pkg.sv
// Types of the tagged memory bus, imported by the arbiter, the tracker, the top level and the bench
`include "mem_defs.svh"

package mem_bus_pkg;

	// Bus command, NONE while idle
	typedef enum logic [1:0] {
		NONE  = 2'd0,
		LOAD  = 2'd1,
		STORE = 2'd2
	} mem_command_t;

	// Tag zero means no response
	typedef logic [`MEM_TAG_WIDTH-1:0]  mem_tag_t;
	typedef logic [`MEM_LINE_WIDTH-1:0] mem_line_t;
	typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;

endpackage

//--- source/client_pkg.sv
// Client side types (owner identity and request payloads), imported by the RTL and the bench
`include "mem_defs.svh"

package client_pkg;

	// Which client port owns a memory request
	typedef enum logic {
		INST = 1'b0,
		DATA = 1'b1
	} client_id_t;

	// Instruction side, line reads only
	typedef struct packed {
		logic [`MEM_ADDR_WIDTH-1:0] addr;
	} inst_req_t;

	// Data side, 97 bits: write flag, address, line
	typedef struct packed {
		logic                       write;
		logic [`MEM_ADDR_WIDTH-1:0] addr;
		logic [`MEM_LINE_WIDTH-1:0] line;
	} data_req_t;

endpackage

//--- source/wb_client_port.sv
// Wishbone classic slave that captures one request and holds it until its completion returns
module wb_client_port
	import mem_bus_pkg::*;
#(
	parameter type req_t = logic
) (
	input  logic      clock,
	input  logic      reset,

	// Wishbone classic slave side
	input  logic      wb_cyc,
	input  logic      wb_stb,
	input  req_t      req,
	output logic      wb_ack,
	output mem_line_t wb_dat_r,

	// Toward the arbiter
	output logic      pending,
	output req_t      pending_req,
	input  logic      accepted,

	// From the tag tracker
	input  logic      done,
	input  mem_line_t done_line
);

	typedef enum logic [1:0] {
		IDLE,
		REQUESTING,
		WAITING
	} state_t;

	state_t state;

	// Offered to the arbiter only while not yet accepted
	assign pending = (state == REQUESTING);

	////////////////////////////////////////////////////////////////////////////
	// Request FSM
	always_ff @(posedge clock) begin
		if (reset) begin
			state  <= IDLE;
			wb_ack <= 1'b0;
		end else begin
			// Ack is a single pulse
			wb_ack <= 1'b0;
			case (state)
				// Master still holds stb during the ack cycle, so skip it
				IDLE: if (wb_cyc && wb_stb && !wb_ack) state <= REQUESTING;
				REQUESTING: if (accepted) state <= WAITING;
				WAITING: begin
					if (done) begin
						wb_ack <= 1'b1;
						state  <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Payload capture and read data
	always_ff @(posedge clock) begin
		// Request frozen from capture until completion
		if (state == IDLE && wb_cyc && wb_stb && !wb_ack) pending_req <= req;
		// Line lands on dat_r together with the ack
		if (state == WAITING && done) wb_dat_r <= done_line;
	end

endmodule

//--- source/request_arbiter.sv
// Picks a pending client request and holds it on the tagged memory bus until memory returns a tag
module request_arbiter
	import mem_bus_pkg::*;
	import client_pkg::*;
(
	input  logic         clock,
	input  logic         reset,

	// Client requests
	input  logic         inst_pending,
	input  inst_req_t    inst_req,
	input  logic         data_pending,
	input  data_req_t    data_req,
	output logic         inst_accepted,
	output logic         data_accepted,

	// Memory bus
	output mem_command_t mem_command,
	output mem_addr_t    mem_addr,
	output mem_line_t    mem_data,
	input  mem_tag_t     mem_response,

	// Acceptance report for the tag tracker
	output logic         accept_valid,
	output mem_tag_t     accept_tag,
	output client_id_t   accept_owner,
	output logic         accept_store
);

	client_id_t held_owner;
	logic       holding;
	logic       accepting;
	logic       can_load;
	logic       load_data;
	logic       load_inst;

	// A command on the bus is the held request
	assign holding   = (mem_command != NONE);
	// Nonzero response ends the hold
	assign accepting = holding && (mem_response != '0);
	assign can_load  = !holding || accepting;

	// Accepted client is still pending this cycle, keep it out
	assign load_data = data_pending && !(accepting && held_owner == DATA);
	assign load_inst = inst_pending && !(accepting && held_owner == INST);

	assign inst_accepted = accepting && (held_owner == INST);
	assign data_accepted = accepting && (held_owner == DATA);

	assign accept_valid = accepting;
	assign accept_tag   = mem_response;
	assign accept_owner = held_owner;
	assign accept_store = (mem_command == STORE);

	////////////////////////////////////////////////////////////////////////////
	// Command and owner, data side first
	always_ff @(posedge clock) begin
		if (reset) begin
			mem_command <= NONE;
			held_owner  <= INST;
		end else if (can_load) begin
			if (load_data) begin
				mem_command <= data_req.write ? STORE : LOAD;
				held_owner  <= DATA;
			end else if (load_inst) begin
				mem_command <= LOAD;
				held_owner  <= INST;
			end else begin
				mem_command <= NONE;
			end
		end
	end

	// Address and line follow the same choice
	always_ff @(posedge clock) begin
		if (can_load) begin
			if (load_data) begin
				mem_addr <= data_req.addr;
				mem_data <= data_req.line;
			end else if (load_inst) begin
				mem_addr <= inst_req.addr;
			end
		end
	end

endmodule

//--- source/tag_tracker.sv
// Records which client owns each outstanding memory tag and routes completions back to it
`include "mem_defs.svh"

module tag_tracker
	import mem_bus_pkg::*;
	import client_pkg::*;
(
	input  logic       clock,
	input  logic       reset,

	// Acceptance report from the arbiter
	input  logic       accept_valid,
	input  mem_tag_t   accept_tag,
	input  client_id_t accept_owner,
	input  logic       accept_store,

	// Returning lines from memory
	input  mem_tag_t   mem_tag,
	input  mem_line_t  mem_data_in,

	// Completions to the client ports
	output logic       inst_done,
	output logic       data_done,
	output mem_line_t  done_line
);

	////////////////////////////////////////////////////////////////////////////
	// Owner table, one entry per tag value
	logic [`NUM_MEM_TAGS-1:0] tag_valid;
	client_id_t               tag_owner [`NUM_MEM_TAGS];

	logic load_accept;
	logic return_hit;

	// Stores complete on acceptance, only loads wait for a line
	assign load_accept = accept_valid && !accept_store;

	// Unknown tags are dropped
	assign return_hit = (mem_tag != '0) && tag_valid[mem_tag];

	always_ff @(posedge clock) begin
		if (reset) begin
			tag_valid <= '0;
			inst_done <= 1'b0;
			data_done <= 1'b0;
		end else begin
			inst_done <= return_hit && (tag_owner[mem_tag] == INST);
			// Store done one cycle after acceptance
			data_done <= (return_hit && (tag_owner[mem_tag] == DATA))
				|| (accept_valid && accept_store);

			// Retire returning tag
			if (return_hit) tag_valid[mem_tag] <= 1'b0;
			// New entry written last so it wins
			if (load_accept) tag_valid[accept_tag] <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Owner entries and returned line
	always_ff @(posedge clock) begin
		if (load_accept) tag_owner[accept_tag] <= accept_owner;
		// Shared line, only the owner with done looks at it
		if (return_hit) done_line <= mem_data_in;
	end

endmodule

//--- source/mem_port_top.sv
// Shared memory port top level, joins the two Wishbone client ports, the arbiter and the tag tracker
module mem_port_top
	import mem_bus_pkg::*;
	import client_pkg::*;
(
	input  logic         clock,
	input  logic         reset,

	// Instruction client, Wishbone classic
	input  logic         inst_cyc,
	input  logic         inst_stb,
	input  mem_addr_t    inst_adr,
	output logic         inst_ack,
	output mem_line_t    inst_dat_r,

	// Data client, Wishbone classic
	input  logic         data_cyc,
	input  logic         data_stb,
	input  logic         data_we,
	input  mem_addr_t    data_adr,
	input  mem_line_t    data_dat_w,
	output logic         data_ack,
	output mem_line_t    data_dat_r,

	// Tagged memory bus
	output mem_command_t mem_command,
	output mem_addr_t    mem_addr,
	output mem_line_t    mem_data,
	input  mem_tag_t     mem_response,
	input  mem_line_t    mem_data_in,
	input  mem_tag_t     mem_tag
);

	// Wishbone fields packed into request payloads
	inst_req_t  inst_req_w;
	data_req_t  data_req_w;

	inst_req_t  inst_pending_req;
	data_req_t  data_pending_req;
	logic       inst_pending;
	logic       data_pending;
	logic       inst_accepted;
	logic       data_accepted;
	logic       inst_done;
	logic       data_done;
	mem_line_t  done_line;
	logic       accept_valid;
	mem_tag_t   accept_tag;
	client_id_t accept_owner;
	logic       accept_store;

	assign inst_req_w = '{addr: inst_adr};
	assign data_req_w = '{write: data_we, addr: data_adr, line: data_dat_w};

	////////////////////////////////////////////////////////////////////////////
	// Client ports
	wb_client_port #(.req_t(inst_req_t)) u_inst_port (
		.clock       (clock),
		.reset       (reset),
		.wb_cyc      (inst_cyc),
		.wb_stb      (inst_stb),
		.req         (inst_req_w),
		.wb_ack      (inst_ack),
		.wb_dat_r    (inst_dat_r),
		.pending     (inst_pending),
		.pending_req (inst_pending_req),
		.accepted    (inst_accepted),
		.done        (inst_done),
		.done_line   (done_line)
	);

	wb_client_port #(.req_t(data_req_t)) u_data_port (
		.clock       (clock),
		.reset       (reset),
		.wb_cyc      (data_cyc),
		.wb_stb      (data_stb),
		.req         (data_req_w),
		.wb_ack      (data_ack),
		.wb_dat_r    (data_dat_r),
		.pending     (data_pending),
		.pending_req (data_pending_req),
		.accepted    (data_accepted),
		.done        (data_done),
		.done_line   (done_line)
	);

	////////////////////////////////////////////////////////////////////////////
	// Memory side
	request_arbiter u_request_arbiter (
		.clock         (clock),
		.reset         (reset),
		.inst_pending  (inst_pending),
		.inst_req      (inst_pending_req),
		.data_pending  (data_pending),
		.data_req      (data_pending_req),
		.inst_accepted (inst_accepted),
		.data_accepted (data_accepted),
		.mem_command   (mem_command),
		.mem_addr      (mem_addr),
		.mem_data      (mem_data),
		.mem_response  (mem_response),
		.accept_valid  (accept_valid),
		.accept_tag    (accept_tag),
		.accept_owner  (accept_owner),
		.accept_store  (accept_store)
	);

	// Completions routed back by tag
	tag_tracker u_tag_tracker (
		.clock        (clock),
		.reset        (reset),
		.accept_valid (accept_valid),
		.accept_tag   (accept_tag),
		.accept_owner (accept_owner),
		.accept_store (accept_store),
		.mem_tag      (mem_tag),
		.mem_data_in  (mem_data_in),
		.inst_done    (inst_done),
		.data_done    (data_done),
		.done_line    (done_line)
	);

endmodule

//--- bench/clock_gen.sv
// Testbench clock and reset source that makes a 40 ns clock and holds reset for the first 10 cycles
module clock_gen (
	output logic clock,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ps;

	// 40 ns period
	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// Release on the 10th rising edge
	initial begin
		reset <= 1'b1;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

//--- bench/mem_model.sv
// Behavioral tagged memory for the testbench, accepts commands after a random delay and returns lines by tag
module mem_model
	import mem_bus_pkg::*;
#(
	parameter mem_line_t fill_pattern = '0
) (
	input  logic         clock,
	input  logic         reset,
	input  logic         slow_return,
	input  mem_command_t mem_command,
	input  mem_addr_t    mem_addr,
	input  mem_line_t    mem_data,
	output mem_tag_t     mem_response,
	output mem_line_t    mem_data_in,
	output mem_tag_t     mem_tag
);
	timeunit 1ns;
	timeprecision 1ps;

	// Sparse line store
	mem_line_t lines [mem_addr_t];
	// Loads in flight, oldest first
	mem_tag_t  ret_tag [$];
	mem_line_t ret_line [$];
	int        ret_wait [$];
	mem_tag_t  next_tag;
	logic      armed;
	int        accept_delay;
	int        return_wait;
	int        seed = 32'hc315a390;

	initial begin
		mem_response <= '0;
		mem_data_in  <= '0;
		mem_tag      <= '0;
	end

	// Unwritten lines read back as the address XOR the fill pattern
	function automatic mem_line_t read_line(input mem_addr_t addr);
		if (lines.exists(addr)) return lines[addr];
		return mem_line_t'(addr) ^ fill_pattern;
	endfunction

	always @(posedge clock) begin
		mem_response <= '0;
		mem_tag      <= '0;
		if (reset) begin
			armed    = 1'b0;
			next_tag = mem_tag_t'(1);
			ret_tag.delete();
			ret_line.delete();
			ret_wait.delete();
		end else begin
			////////////////////////////////////////////////////////////////////////////
			// Return path, in order
			if (ret_tag.size() != 0) begin
				if (ret_wait[0] == 0) begin
					mem_tag     <= ret_tag.pop_front();
					mem_data_in <= ret_line.pop_front();
					void'(ret_wait.pop_front());
				end else begin
					ret_wait[0] = ret_wait[0] - 1;
				end
			end
			////////////////////////////////////////////////////////////////////////////
			// Accept path
			if (mem_response != '0) begin
				// Bus still shows the request being accepted
				armed = 1'b0;
				if (mem_command == STORE) begin
					lines[mem_addr] = mem_data;
				end else if (mem_command == LOAD) begin
					if (slow_return) return_wait = 11;
					else return_wait = int'($unsigned($random(seed)) % 4);
					ret_tag.push_back(mem_response);
					ret_line.push_back(read_line(mem_addr));
					ret_wait.push_back(return_wait);
				end
			end else if (mem_command != NONE) begin
				// New command, pick 0 to 3 idle cycles
				if (!armed) begin
					armed        = 1'b1;
					accept_delay = int'($unsigned($random(seed)) % 4);
				end
				if (accept_delay == 0) begin
					mem_response <= next_tag;
					// Tags 1 to 15 in rotation
					next_tag = (next_tag == '1) ? mem_tag_t'(1) : next_tag + mem_tag_t'(1);
				end else begin
					accept_delay = accept_delay - 1;
				end
			end
		end
	end

endmodule

//--- bench/mem_port_chk.sv
// Bus rule assertions for the shared memory port, bound into the top level
module mem_port_chk
	import mem_bus_pkg::*;
(
	input logic         clock,
	input logic         reset,
	input mem_command_t mem_command,
	input mem_tag_t     mem_response,
	input logic         inst_cyc,
	input logic         inst_ack,
	input logic         data_cyc,
	input logic         data_ack
);
	timeunit 1ns;
	timeprecision 1ps;

	int command_errors = 0;
	int ack_errors     = 0;
	int cyc_errors     = 0;

	// Held command frozen until memory returns a tag
	a_command_held: assert property (@(posedge clock) disable iff (reset)
		(mem_command != NONE && mem_response == '0) |=> $stable(mem_command))
	else begin
		command_errors++;
		$error("mem_command changed while mem_response was zero");
	end

	// Single-cycle acks on both ports
	a_ack_pulse: assert property (@(posedge clock) disable iff (reset)
		(inst_ack || data_ack) |=> !((inst_ack && $past(inst_ack)) || (data_ack && $past(data_ack))))
	else begin
		ack_errors++;
		$error("ack held high for more than one cycle");
	end

	// Ack only inside a bus cycle
	a_ack_in_cycle: assert property (@(posedge clock) disable iff (reset)
		!((inst_ack && !inst_cyc) || (data_ack && !data_cyc)))
	else begin
		cyc_errors++;
		$error("ack raised without cyc");
	end

endmodule

bind mem_port_top mem_port_chk u_mem_port_chk (
	.clock        (clock),
	.reset        (reset),
	.mem_command  (mem_command),
	.mem_response (mem_response),
	.inst_cyc     (inst_cyc),
	.inst_ack     (inst_ack),
	.data_cyc     (data_cyc),
	.data_ack     (data_ack)
);

//--- bench/mem_port_tb.sv
// Testbench top for the shared memory port, runs a table of client requests and checks every line
`include "mem_defs.svh"

module mem_port_tb
	import mem_bus_pkg::*;
	import client_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int        num_steps    = 7;
	localparam int        cycle_limit  = 40 * num_steps + 10;
	localparam mem_line_t fill_pattern = 64'h5a5a_0f0f_c3c3_9696;
	localparam mem_line_t line_a       = 64'h0123_4567_89ab_cdef;
	localparam mem_line_t line_b       = 64'hfeed_face_cafe_f00d;

	// One stimulus row, unused fields don't care
	typedef struct packed {
		logic      use_inst;
		logic      use_data;
		logic      slow;
		inst_req_t inst_req;
		data_req_t data_req;
		mem_line_t inst_exp;
		mem_line_t data_exp;
	} step_t;

	logic         clock;
	logic         reset;
	logic         inst_cyc;
	logic         inst_stb;
	mem_addr_t    inst_adr;
	logic         inst_ack;
	mem_line_t    inst_dat_r;
	logic         data_cyc;
	logic         data_stb;
	logic         data_we;
	mem_addr_t    data_adr;
	mem_line_t    data_dat_w;
	logic         data_ack;
	mem_line_t    data_dat_r;
	mem_command_t mem_command;
	mem_addr_t    mem_addr;
	mem_line_t    mem_data;
	mem_tag_t     mem_response;
	mem_line_t    mem_data_in;
	mem_tag_t     mem_tag;
	logic         slow_return;

	step_t steps [num_steps];
	int    error_count  = 0;
	int    failed_tests = 0;
	int    cycle_count  = 0;
	int    outstanding;
	int    protocol_errors;

	clock_gen u_clock_gen (
		.clock (clock),
		.reset (reset)
	);

	mem_port_top u_mem_port_top (.*);

	mem_model #(.fill_pattern(fill_pattern)) u_mem_model (
		.clock        (clock),
		.reset        (reset),
		.slow_return  (slow_return),
		.mem_command  (mem_command),
		.mem_addr     (mem_addr),
		.mem_data     (mem_data),
		.mem_response (mem_response),
		.mem_data_in  (mem_data_in),
		.mem_tag      (mem_tag)
	);

	// Loads accepted but not yet returned
	always @(posedge clock) begin
		if (reset) outstanding <= 0;
		else outstanding <= outstanding + ((mem_command == LOAD && mem_response != '0) ? 1 : 0)
			- ((mem_tag != '0) ? 1 : 0);
	end

	// Run limit
	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Timeout after %0d cycles, a request never got its ack", cycle_limit);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic mem_line_t fill_line(input mem_addr_t addr);
		return {{(`MEM_LINE_WIDTH - `MEM_ADDR_WIDTH){1'b0}}, addr} ^ fill_pattern;
	endfunction

	task automatic fill_table();
		// inst, data, slow, inst addr, data {we, addr, line}, inst line, data line
		steps[0] = '{1'b1, 1'b0, 1'b0, '{32'h0000_1000}, '{1'b0, 32'h0, 64'h0},
			fill_line(32'h0000_1000), 64'h0};
		steps[1] = '{1'b0, 1'b1, 1'b0, '{32'h0}, '{1'b1, 32'h0000_2000, line_a}, 64'h0, 64'h0};
		steps[2] = '{1'b0, 1'b1, 1'b0, '{32'h0}, '{1'b0, 32'h0000_2000, 64'h0}, 64'h0, line_a};
		steps[3] = '{1'b1, 1'b1, 1'b0, '{32'h0000_3000}, '{1'b1, 32'h0000_4000, line_b},
			fill_line(32'h0000_3000), 64'h0};
		// Slow returns, two loads in flight
		steps[4] = '{1'b1, 1'b1, 1'b1, '{32'h0000_3040}, '{1'b0, 32'h0000_4000, 64'h0},
			fill_line(32'h0000_3040), line_b};
		steps[5] = '{1'b1, 1'b0, 1'b0, '{32'h0000_2000}, '{1'b0, 32'h0, 64'h0}, line_a, 64'h0};
		steps[6] = '{1'b1, 1'b1, 1'b1, '{32'h0000_4000}, '{1'b0, 32'h0000_5000, 64'h0},
			line_b, fill_line(32'h0000_5000)};
	endtask

	task automatic check_line(input string what, input mem_line_t got, input mem_line_t expected);
		assert (got == expected) else begin
			$display("FAIL %0t: %s returned %h, expected %h", $time, what, got, expected);
			error_count++;
		end
	endtask

	task automatic check_at_least(input string what, input int value, input int minimum);
		assert (value >= minimum) else begin
			$display("FAIL %0t: %s was %0d, expected at least %0d", $time, what, value, minimum);
			error_count++;
		end
	endtask

	// Idle bus and no acks right after reset
	task automatic check_reset_state();
		int errors_before;
		errors_before = error_count;
		repeat (4) begin
			@(posedge clock);
			assert (mem_command == NONE && !inst_ack && !data_ack) else begin
				$display("FAIL %0t: bus busy after reset, command %0d, acks %b%b", $time,
					mem_command, inst_ack, data_ack);
				error_count++;
			end
		end
		if (error_count != errors_before) failed_tests++;
		$display("Reset check %s", (error_count == errors_before) ? "ok" : "failed");
	endtask

	task automatic run_step(input int index);
		step_t     s;
		logic      inst_seen;
		logic      data_seen;
		logic      first_seen;
		mem_addr_t first_addr;
		int        cycles;
		int        inst_cycles;
		int        data_cycles;
		int        peak;
		int        errors_before;
		s             = steps[index];
		errors_before = error_count;
		inst_seen     = !s.use_inst;
		data_seen     = !s.use_data;
		first_seen    = 1'b0;
		first_addr    = '0;
		cycles        = 0;
		inst_cycles   = 4;
		data_cycles   = 4;
		peak          = 0;
		@(posedge clock);
		inst_cyc    <= s.use_inst;
		inst_stb    <= s.use_inst;
		inst_adr    <= s.inst_req.addr;
		data_cyc    <= s.use_data;
		data_stb    <= s.use_data;
		data_we     <= s.data_req.write;
		data_adr    <= s.data_req.addr;
		data_dat_w  <= s.data_req.line;
		slow_return <= s.slow;
		while (!(inst_seen && data_seen)) begin
			@(posedge clock);
			cycles++;
			if (outstanding > peak) peak = outstanding;
			// First command of the step
			if (!first_seen && mem_command != NONE) begin
				first_seen = 1'b1;
				first_addr = mem_addr;
			end
			if (!inst_seen && inst_ack) begin
				inst_seen   = 1'b1;
				inst_cycles = cycles;
				inst_cyc   <= 1'b0;
				inst_stb   <= 1'b0;
				check_line("instruction read", inst_dat_r, s.inst_exp);
			end
			if (!data_seen && data_ack) begin
				data_seen   = 1'b1;
				data_cycles = cycles;
				data_cyc   <= 1'b0;
				data_stb   <= 1'b0;
				// Store ack carries no line
				if (!s.data_req.write) check_line("data load", data_dat_r, s.data_exp);
			end
		end
		if (s.use_inst && s.use_data) begin
			assert (first_addr == s.data_req.addr) else begin
				$display("FAIL %0t: first command went to %h, data address %h", $time,
					first_addr, s.data_req.addr);
				error_count++;
			end
		end
		if (s.slow && s.use_inst && s.use_data) check_at_least("loads in flight", peak, 2);
		check_at_least("instruction ack latency", inst_cycles, 4);
		check_at_least("data ack latency", data_cycles, 4);
		if (error_count != errors_before) failed_tests++;
		$display("Step %0d %s after %0d cycles", index,
			(error_count == errors_before) ? "ok" : "failed", cycles);
	endtask

	initial begin
		inst_cyc    <= 1'b0;
		inst_stb    <= 1'b0;
		inst_adr    <= '0;
		data_cyc    <= 1'b0;
		data_stb    <= 1'b0;
		data_we     <= 1'b0;
		data_adr    <= '0;
		data_dat_w  <= '0;
		slow_return <= 1'b0;
		fill_table();
		while (reset !== 1'b0) @(posedge clock);
		check_reset_state();
		for (int i = 0; i < num_steps; i++) run_step(i);
		protocol_errors = u_mem_port_top.u_mem_port_chk.command_errors
			+ u_mem_port_top.u_mem_port_chk.ack_errors
			+ u_mem_port_top.u_mem_port_chk.cyc_errors;
		if (protocol_errors != 0) $display("Bound bus assertions failed %0d times", protocol_errors);
		$display("Tests %0d, passed %0d, failed %0d, assertion failures %0d", num_steps + 1,
			num_steps + 1 - failed_tests, failed_tests, protocol_errors);
		if (failed_tests == 0 && protocol_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- tb.f
+incdir+source
source/mem_bus_pkg.sv
source/client_pkg.sv
source/wb_client_port.sv
source/request_arbiter.sv
source/tag_tracker.sv
source/mem_port_top.sv
bench/clock_gen.sv
bench/mem_model.sv
bench/mem_port_chk.sv
bench/mem_port_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the shared memory port testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f tb.f --top-module mem_port_tb -o mem_port_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/mem_port_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
echo "Simulation finished without failure"
exit 0
